/* files.f */
fetch_pkg.sv
pc_select.sv
fetch_ctrl.sv
fetch_fifo.sv
if_id_reg.sv
if_stage.sv
tb_instr_mem.sv
tb_if_stage.sv

/* run.sh */
#!/usr/bin/env bash
# build the fetch stage testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/100ps -j 0 -f files.f \
  --top-module tb_if_stage -o tb_if_stage \
  && ./obj_dir/tb_if_stage > sim.log 2>&1 \
  || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qs "Simulation PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

/* tb_if_stage.sv */
//////////////////////////////
// fetch stage testbench
// random redirects and decode ready,
// checked against a pc model
//////////////////////////////

module tb_if_stage;
  timeunit 1ns;
  timeprecision 100ps;
  import fetch_pkg::*;

  // about 80 words and 20 redirects plus hold phases, each far below 200 cycles
  localparam int TimeoutCycles = 20000;

  logic        clk;
  logic        rst_n;
  logic        req;
  logic        pc_set;
  pc_sel_e     pc_mux;
  exc_pc_sel_e exc_pc_mux;
  irq_id_t     irq_id;
  addr_t       branch_target;
  addr_t       boot_addr;
  csr_pc_t     csr;
  logic        mtvec_init;
  logic        instr_req;
  addr_t       instr_addr;
  logic        instr_gnt;
  logic        instr_rvalid;
  instr_t      instr_rdata;
  logic        instr_err;
  if_id_t      if_id;
  logic        valid_id;
  logic        new_id;
  logic        id_ready;
  logic        valid_clear;
  addr_t       pc_if;
  logic        if_busy;

  // main process bookkeeping
  string cur_test;
  int    main_checks;
  int    main_errors;
  int    checks0;
  int    errors0;
  int    tests_run;
  int    hold_cnt;
  int    err0;
  int    cycle_cnt;
  logic  rand_id;

  // monitor bookkeeping
  int    mon_checks;
  int    mon_errors;
  int    new_cnt;
  int    init_cnt;
  int    err_seen;
  addr_t exp_pc;
  addr_t pc_prev;
  logic  booted;
  logic  valid_prev;
  logic  clear_prev;
  logic  new_prev;

  if_stage u_if_stage (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .req_i              (req),
    .pc_set_i           (pc_set),
    .pc_mux_i           (pc_mux),
    .exc_pc_mux_i       (exc_pc_mux),
    .irq_id_i           (irq_id),
    .branch_target_i    (branch_target),
    .boot_addr_i        (boot_addr),
    .csr_i              (csr),
    .csr_mtvec_init_o   (mtvec_init),
    .instr_req_o        (instr_req),
    .instr_addr_o       (instr_addr),
    .instr_gnt_i        (instr_gnt),
    .instr_rvalid_i     (instr_rvalid),
    .instr_rdata_i      (instr_rdata),
    .instr_err_i        (instr_err),
    .if_id_o            (if_id),
    .instr_valid_id_o   (valid_id),
    .instr_new_id_o     (new_id),
    .id_in_ready_i      (id_ready),
    .instr_valid_clear_i(valid_clear),
    .pc_if_o            (pc_if),
    .if_busy_o          (if_busy)
  );

  tb_instr_mem u_instr_mem (
    .clk_i   (clk),
    .rst_ni  (rst_n),
    .req_i   (instr_req),
    .addr_i  (instr_addr),
    .gnt_o   (instr_gnt),
    .rvalid_o(instr_rvalid),
    .rdata_o (instr_rdata),
    .err_o   (instr_err)
  );

  always #2 clk = ~clk;

  //////////////////////////////
  // reference rules
  //////////////////////////////

  // where fetch restarts after a redirect
  function automatic addr_t redirect_target(pc_sel_e sel, exc_pc_sel_e exc, irq_id_t irq,
                                            addr_t boot, addr_t target, csr_pc_t c);
    addr_t base;
    base = {c.mtvec[31:8], 8'h00};
    case (sel)
      PC_BOOT: return {boot[31:8], 8'h80};
      PC_JUMP: return {target[31:2], 2'b00};
      PC_EXC:  return (exc == EXC_PC_IRQ) ? base + {25'd0, irq, 2'b00} : base;
      default: return c.mepc;
    endcase
  endfunction

  function automatic instr_t mem_word(addr_t a);
    return a ^ 32'hA5C3_0000;
  endfunction

  function automatic logic mem_err(addr_t a);
    return (a[11:8] == 4'hE);
  endfunction

  function automatic addr_t rand_addr();
    return addr_t'($urandom()) & 32'hFFFF_FFFC;
  endfunction

  //////////////////////////////
  // monitor
  //////////////////////////////

  // outputs sampled mid cycle, well away from both edges
  always @(negedge clk) begin
    if (!rst_n) begin
      booted     = 1'b0;
      valid_prev = 1'b0;
      clear_prev = 1'b0;
      new_prev   = 1'b0;
      pc_prev    = '0;
      exp_pc     = '0;
    end else begin
      mon_checks += 3;
      if (!booted && instr_req) begin
        mon_errors++;
        $display("%s: fetch request seen before the first redirect", cur_test);
      end
      // valid holds until cleared, set by every new word
      if (valid_id !== (new_id | (valid_prev & ~clear_prev))) begin
        mon_errors++;
        $display("%s: valid flag did not follow the new and clear handshake", cur_test);
      end
      if (mtvec_init !== (pc_set && pc_mux == PC_BOOT)) begin
        mon_errors++;
        $display("%s: mtvec init strobe outside a boot redirect", cur_test);
      end
      if (mtvec_init) begin
        init_cnt++;
      end
      if (new_id) begin
        new_cnt++;
        mon_checks += 4;
        if (if_id.pc !== exp_pc) begin
          mon_errors++;
          $display("** Error %s pc: expected %h actual %h", cur_test, exp_pc, if_id.pc);
        end
        if (if_id.instr !== mem_word(exp_pc)) begin
          mon_errors++;
          $display("** Error %s instr: expected %h actual %h", cur_test, mem_word(exp_pc),
                   if_id.instr);
        end
        if (if_id.fetch_err !== mem_err(exp_pc)) begin
          mon_errors++;
          $display("** Error %s fetch_err: expected %b actual %b", cur_test, mem_err(exp_pc),
                   if_id.fetch_err);
        end
        if (new_prev && if_id.pc == pc_prev) begin
          mon_errors++;
          $display("%s: same entry flagged new in two cycles", cur_test);
        end
        if (if_id.fetch_err) begin
          err_seen++;
        end
        pc_prev = if_id.pc;
        exp_pc  = exp_pc + 32'd4;
      end
      // queue head is the next word decode will get
      if (booted) begin
        mon_checks++;
        if (pc_if !== exp_pc) begin
          mon_errors++;
          $display("** Error %s pc_if: expected %h actual %h", cur_test, exp_pc, pc_if);
        end
      end
      // a word shown in the redirect cycle still belongs to the old stream
      if (pc_set) begin
        exp_pc = redirect_target(pc_mux, exc_pc_mux, irq_id, boot_addr, branch_target, csr);
        booted = 1'b1;
      end
      valid_prev = valid_id;
      clear_prev = valid_clear;
      new_prev   = new_id;
    end
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  // one cycle, inputs move 1 ns after the edge
  task automatic step();
    @(posedge clk);
    #1;
    if (rand_id) begin
      id_ready    = ($urandom_range(0, 3) != 0);
      valid_clear = ($urandom_range(0, 1) == 1);
    end
  endtask

  task automatic idle_cycles(int n);
    repeat (n) step();
  endtask

  task automatic wait_new(int n);
    int target;
    target = new_cnt + n;
    while (new_cnt < target) begin
      step();
    end
  endtask

  task automatic redirect(pc_sel_e sel, exc_pc_sel_e exc, irq_id_t irq, addr_t target,
                          addr_t mepc, addr_t mtvec);
    step();
    pc_set        = 1'b1;
    pc_mux        = sel;
    exc_pc_mux    = exc;
    irq_id        = irq;
    branch_target = target;
    csr.mepc      = mepc;
    csr.mtvec     = mtvec;
    step();
    pc_set = 1'b0;
  endtask

  task automatic start_test(string name);
    cur_test = name;
    checks0  = main_checks + mon_checks;
    errors0  = main_errors + mon_errors;
    tests_run++;
  endtask

  task automatic end_test();
    $display("test %s: %0d checks, %0d errors", cur_test,
             main_checks + mon_checks - checks0, main_errors + mon_errors - errors0);
  endtask

  //////////////////////////////
  // watchdog
  //////////////////////////////

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TimeoutCycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, test %s did not finish", cycle_cnt, cur_test);
    $display("Simulation FAILED");
    $finish;
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'h884c_168b));
    clk           = 1'b0;
    rst_n         = 1'b0;
    req           = 1'b0;
    pc_set        = 1'b0;
    pc_mux        = PC_BOOT;
    exc_pc_mux    = EXC_PC_EXC;
    irq_id        = '0;
    branch_target = '0;
    boot_addr     = rand_addr();
    csr           = '0;
    id_ready      = 1'b0;
    valid_clear   = 1'b0;
    rand_id       = 1'b0;
    main_checks   = 0;
    main_errors   = 0;
    tests_run     = 0;

    // boot, nothing moves before the first redirect
    start_test("boot");
    idle_cycles(8);
    main_checks++;
    if (instr_req | valid_id | new_id | mtvec_init | if_busy) begin
      main_errors++;
      $display("%s: outputs not low during reset", cur_test);
    end
    rst_n = 1'b1;
    req   = 1'b1;
    idle_cycles(4);
    rand_id = 1'b1;
    redirect(PC_BOOT, EXC_PC_EXC, irq_id_t'(0), 32'd0, 32'd0, 32'd0);
    wait_new(1);
    main_checks++;
    if (init_cnt != 1) begin
      main_errors++;
      $display("%s: expected one mtvec init pulse, saw %0d", cur_test, init_cnt);
    end
    end_test();

    start_test("sequential");
    wait_new(40);
    end_test();

    // redirects land with words still in flight
    start_test("redirect");
    repeat (12) begin
      redirect(($urandom_range(0, 1) == 1) ? PC_JUMP : PC_ERET, EXC_PC_EXC, irq_id_t'(0),
               addr_t'($urandom()), rand_addr(), rand_addr());
      idle_cycles(int'($urandom_range(0, 4)));
    end
    wait_new(3);
    end_test();

    start_test("exc_vector");
    repeat (8) begin
      redirect(PC_EXC, ($urandom_range(0, 1) == 1) ? EXC_PC_IRQ : EXC_PC_EXC,
               irq_id_t'($urandom_range(0, 31)), rand_addr(), rand_addr(), rand_addr());
      wait_new(1);
    end
    end_test();

    // run from page D into the error page E
    start_test("bus_error");
    err0 = err_seen;
    redirect(PC_JUMP, EXC_PC_EXC, irq_id_t'(0), (rand_addr() & 32'hFFFF_F000) | 32'h0000_0DF0,
             rand_addr(), rand_addr());
    wait_new(24);
    main_checks++;
    if (err_seen == err0) begin
      main_errors++;
      $display("%s: no bus error reached decode", cur_test);
    end
    end_test();

    // decode stalls, then clears
    start_test("valid_hold");
    rand_id = 1'b0;
    step();
    id_ready    = 1'b1;
    valid_clear = 1'b0;
    wait_new(1);
    step();
    id_ready = 1'b0;
    step();
    hold_cnt = new_cnt;
    repeat (10) begin
      step();
      main_checks++;
      if (valid_id !== 1'b1) begin
        main_errors++;
        $display("%s: valid dropped while clear was low", cur_test);
      end
    end
    main_checks++;
    if (new_cnt != hold_cnt) begin
      main_errors++;
      $display("%s: new flag rose while decode was not ready", cur_test);
    end
    step();
    valid_clear = 1'b1;
    step();
    valid_clear = 1'b0;
    main_checks++;
    if (valid_id !== 1'b0) begin
      main_errors++;
      $display("%s: valid stayed high after a clear", cur_test);
    end
    rand_id = 1'b1;
    wait_new(4);
    end_test();

    $display("tests %0d, checks %0d, errors %0d", tests_run, main_checks + mon_checks,
             main_errors + mon_errors);
    if (main_errors + mon_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* tb_instr_mem.sv */
//////////////////////////////
// instruction memory responder
// random grant delay, in-order responses
//////////////////////////////

module tb_instr_mem (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  fetch_pkg::addr_t  addr_i,
  output logic              gnt_o,
  output logic              rvalid_o,
  output fetch_pkg::instr_t rdata_o,
  output logic              err_o
);
  timeunit 1ns;
  timeprecision 100ps;
  import fetch_pkg::*;

  // granted addresses and the cycle each answer is due
  addr_t addr_q[$];
  int    due_q[$];
  int    now;
  int    due;
  int    last_due;
  int    gnt_wait;
  logic  req_seen;
  logic  accept;
  addr_t acc_addr;

  initial begin
    gnt_o    = 1'b1;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;
    now      = 0;
    last_due = 0;
    gnt_wait = 0;
    forever begin
      // bus is stable halfway through the cycle
      @(negedge clk_i);
      req_seen = req_i;
      accept   = rst_ni & req_i & gnt_o;
      acc_addr = addr_i;
      @(posedge clk_i);
      #1;
      now++;
      if (accept) begin
        // answer 1 to 3 cycles after the grant, never overtaking
        due = now + int'($urandom_range(0, 2));
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        due_q.push_back(due);
        addr_q.push_back(acc_addr);
        // next request waits 0 to 2 cycles for its grant
        gnt_wait = int'($urandom_range(0, 2));
      end else if (req_seen && gnt_wait > 0) begin
        gnt_wait--;
      end
      gnt_o    = (gnt_wait == 0);
      rvalid_o = 1'b0;
      rdata_o  = '0;
      err_o    = 1'b0;
      if (due_q.size() > 0 && due_q[0] == now) begin
        rvalid_o = 1'b1;
        // word pattern and error page
        rdata_o  = addr_q[0] ^ 32'hA5C3_0000;
        err_o    = (addr_q[0][11:8] == 4'hE);
        void'(due_q.pop_front());
        void'(addr_q.pop_front());
      end
    end
  end

endmodule

/* if_stage.sv */
//////////////////////////////
// instruction fetch stage
// pc select, bus fetch, prefetch
// queue and if-id register
//////////////////////////////

module if_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  // redirect control
  input  logic                   pc_set_i,
  input  fetch_pkg::pc_sel_e     pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  fetch_pkg::irq_id_t     irq_id_i,
  input  fetch_pkg::addr_t       branch_target_i,
  input  fetch_pkg::addr_t       boot_addr_i,
  input  fetch_pkg::csr_pc_t     csr_i,
  output logic                   csr_mtvec_init_o,
  // instruction bus
  output logic                   instr_req_o,
  output fetch_pkg::addr_t       instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  fetch_pkg::instr_t      instr_rdata_i,
  input  logic                   instr_err_i,
  // decode side
  output fetch_pkg::if_id_t      if_id_o,
  output logic                   instr_valid_id_o,
  output logic                   instr_new_id_o,
  input  logic                   id_in_ready_i,
  input  logic                   instr_valid_clear_i,
  output fetch_pkg::addr_t       pc_if_o,
  output logic                   if_busy_o
);
  import fetch_pkg::*;

  addr_t        redirect_addr;
  logic         push;
  fetch_entry_t push_entry;
  logic         pop;
  logic [1:0]   count;
  logic         head_valid;
  if_id_t       head;

  pc_select u_pc_select (
    .pc_set_i        (pc_set_i),
    .pc_mux_i        (pc_mux_i),
    .exc_pc_mux_i    (exc_pc_mux_i),
    .irq_id_i        (irq_id_i),
    .boot_addr_i     (boot_addr_i),
    .branch_target_i (branch_target_i),
    .csr_i           (csr_i),
    .redirect_addr_o (redirect_addr),
    .csr_mtvec_init_o(csr_mtvec_init_o)
  );

  fetch_ctrl u_fetch_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .pc_set_i       (pc_set_i),
    .redirect_addr_i(redirect_addr),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .count_i        (count),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .push_o         (push),
    .push_entry_o   (push_entry),
    .if_busy_o      (if_busy_o)
  );

  // queue empties on every redirect
  fetch_fifo u_fetch_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (pc_set_i),
    .flush_addr_i(redirect_addr),
    .push_i      (push),
    .push_entry_i(push_entry),
    .pop_i       (pop),
    .head_valid_o(head_valid),
    .head_o      (head),
    .count_o     (count)
  );

  if_id_reg u_if_id_reg (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .head_valid_i       (head_valid),
    .head_i             (head),
    .id_in_ready_i      (id_in_ready_i),
    .pc_set_i           (pc_set_i),
    .instr_valid_clear_i(instr_valid_clear_i),
    .pop_o              (pop),
    .if_id_o            (if_id_o),
    .instr_valid_id_o   (instr_valid_id_o),
    .instr_new_id_o     (instr_new_id_o)
  );

  assign pc_if_o = head.pc;

endmodule

/* if_id_reg.sv */
//////////////////////////////
// if-id pipeline register
// payload, sticky valid and new pulse
//////////////////////////////

module if_id_reg (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              head_valid_i,
  input  fetch_pkg::if_id_t head_i,
  input  logic              id_in_ready_i,
  input  logic              pc_set_i,
  input  logic              instr_valid_clear_i,
  output logic              pop_o,
  output fetch_pkg::if_id_t if_id_o,
  output logic              instr_valid_id_o,
  output logic              instr_new_id_o
);
  import fetch_pkg::*;

  if_id_t if_id_q;
  logic   valid_q, valid_d;
  logic   new_q, new_d;

  // decode takes the head whenever it is ready
  assign pop_o = head_valid_i & id_in_ready_i;

  // a redirect in the same cycle kills the incoming word
  assign new_d = pop_o & ~pc_set_i;

  // valid sticks until decode clears it
  assign valid_d = new_d | (valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      new_q   <= new_d;
    end
  end

  // payload frozen while decode stalls
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      if_id_q <= head_i;
    end
  end

  assign if_id_o          = if_id_q;
  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

endmodule

/* fetch_fifo.sv */
//////////////////////////////
// prefetch queue
// two fetched words plus the pc
// of the oldest one
//////////////////////////////

module fetch_fifo (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  input  fetch_pkg::addr_t        flush_addr_i,
  input  logic                    push_i,
  input  fetch_pkg::fetch_entry_t push_entry_i,
  input  logic                    pop_i,
  output logic                    head_valid_o,
  output fetch_pkg::if_id_t       head_o,
  output logic [1:0]              count_o
);
  import fetch_pkg::*;

  fetch_entry_t mem_q [FifoDepth];
  addr_t        head_pc_q;
  logic [1:0]   count_q, count_d;
  logic [1:0]   wr_idx;
  logic         wr_en;
  logic         rd_en;

  assign head_valid_o = (count_q != 2'd0);

  // flush wins over both ports
  assign wr_en = push_i & ~flush_i;
  assign rd_en = pop_i & head_valid_o & ~flush_i;

  // new word lands after the survivors of a pop
  assign wr_idx = count_q - 2'(rd_en);

  //////////////////////////////
  // occupancy
  //////////////////////////////

  always_comb begin
    count_d = count_q;
    if (flush_i) begin
      count_d = 2'd0;
    end else begin
      count_d = count_q + 2'(wr_en) - 2'(rd_en);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= 2'd0;
    end else begin
      count_q <= count_d;
    end
  end

  //////////////////////////////
  // storage
  //////////////////////////////

  // entry 0 is the head and shifts in from entry 1
  always_ff @(posedge clk_i) begin
    if (wr_en && wr_idx == 2'd0) begin
      mem_q[0] <= push_entry_i;
    end else if (rd_en) begin
      mem_q[0] <= mem_q[1];
    end
    if (wr_en && wr_idx == 2'd1) begin
      mem_q[1] <= push_entry_i;
    end
  end

  // pc of the head, restarts at the redirect target
  always_ff @(posedge clk_i) begin
    if (flush_i) begin
      head_pc_q <= flush_addr_i;
    end else if (rd_en) begin
      head_pc_q <= head_pc_q + 32'd4;
    end
  end

  assign head_o.instr     = mem_q[0].instr;
  assign head_o.pc        = head_pc_q;
  assign head_o.fetch_err = mem_q[0].err;

  assign count_o = count_q;

endmodule

/* fetch_ctrl.sv */
//////////////////////////////
// fetch bus control
// issues requests, tracks outstanding
// responses and drops stale ones
//////////////////////////////

module fetch_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  logic                    pc_set_i,
  input  fetch_pkg::addr_t        redirect_addr_i,
  input  logic                    instr_gnt_i,
  input  logic                    instr_rvalid_i,
  input  fetch_pkg::instr_t       instr_rdata_i,
  input  logic                    instr_err_i,
  input  logic [1:0]              count_i,
  output logic                    instr_req_o,
  output fetch_pkg::addr_t        instr_addr_o,
  output logic                    push_o,
  output fetch_pkg::fetch_entry_t push_entry_o,
  output logic                    if_busy_o
);
  import fetch_pkg::*;

  typedef enum logic {
    IDLE,
    FETCH
  } state_e;

  state_e     state_q, state_d;
  addr_t      fetch_addr_q, fetch_addr_d;
  addr_t      hold_addr_q;
  logic       hold_q, hold_d;
  logic       stale_q, stale_d;
  logic [1:0] outstanding_q, outstanding_d;
  logic [1:0] discard_q, discard_d;
  logic [2:0] in_use;
  logic       can_issue;
  logic       gnt_accept;
  logic       drop;

  //////////////////////////////
  // request side
  //////////////////////////////

  // no fetching before the first redirect
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (pc_set_i) state_d = FETCH;
      FETCH:   state_d = FETCH;
      default: state_d = IDLE;
    endcase
  end

  // words in flight plus words queued must fit the queue
  assign in_use    = {1'b0, outstanding_q} + {1'b0, count_i};
  assign can_issue = (state_q == FETCH) & req_i & ~pc_set_i & (in_use < 3'(FifoDepth));

  // an ungranted request stays up with the same address
  assign instr_req_o  = hold_q | can_issue;
  assign instr_addr_o = stale_q ? hold_addr_q : fetch_addr_q;
  assign gnt_accept   = instr_req_o & instr_gnt_i;

  assign hold_d = instr_req_o & ~instr_gnt_i;
  // held request overtaken by a redirect
  assign stale_d = hold_d & (pc_set_i | stale_q);

  // stale grants leave the next address untouched
  always_comb begin
    fetch_addr_d = fetch_addr_q;
    if (pc_set_i) begin
      fetch_addr_d = redirect_addr_i;
    end else if (gnt_accept && !stale_q) begin
      fetch_addr_d = fetch_addr_q + 32'd4;
    end
  end

  //////////////////////////////
  // response side
  //////////////////////////////

  assign drop   = instr_rvalid_i & (discard_q != 2'd0);
  assign push_o = instr_rvalid_i & ~drop & ~pc_set_i;

  assign push_entry_o.instr = instr_rdata_i;
  assign push_entry_o.err   = instr_err_i;

  assign outstanding_d = outstanding_q + 2'(gnt_accept) - 2'(instr_rvalid_i);

  // a redirect marks everything still in flight for dropping
  always_comb begin
    if (pc_set_i) begin
      discard_d = outstanding_d;
    end else begin
      discard_d = discard_q - 2'(drop) + 2'(gnt_accept & stale_q);
    end
  end

  assign if_busy_o = (outstanding_q != 2'd0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= IDLE;
      hold_q        <= 1'b0;
      stale_q       <= 1'b0;
      outstanding_q <= 2'd0;
      discard_q     <= 2'd0;
    end else begin
      state_q       <= state_d;
      hold_q        <= hold_d;
      stale_q       <= stale_d;
      outstanding_q <= outstanding_d;
      discard_q     <= discard_d;
    end
  end

  always_ff @(posedge clk_i) begin
    fetch_addr_q <= fetch_addr_d;
    if (hold_d) begin
      hold_addr_q <= instr_addr_o;
    end
  end

endmodule

/* pc_select.sv */
//////////////////////////////
// next pc select
// picks the redirect address and
// computes the trap vector
//////////////////////////////

module pc_select (
  input  logic                   pc_set_i,
  input  fetch_pkg::pc_sel_e     pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  fetch_pkg::irq_id_t     irq_id_i,
  input  fetch_pkg::addr_t       boot_addr_i,
  input  fetch_pkg::addr_t       branch_target_i,
  input  fetch_pkg::csr_pc_t     csr_i,
  output fetch_pkg::addr_t       redirect_addr_o,
  output logic                   csr_mtvec_init_o
);
  import fetch_pkg::*;

  addr_t boot_pc;
  addr_t mtvec_base;
  addr_t exc_pc;
  addr_t jump_pc;

  // boot page base plus the reset entry offset
  assign boot_pc = {boot_addr_i[31:VecBaseLsb], {VecBaseLsb{1'b0}}} + addr_t'(BootOffset);

  // trap table base, low bits dropped
  assign mtvec_base = {csr_i.mtvec[31:VecBaseLsb], {VecBaseLsb{1'b0}}};

  // jumps are always word aligned here
  assign jump_pc = {branch_target_i[31:2], 2'b00};

  //////////////////////////////
  // trap vector
  //////////////////////////////

  always_comb begin
    unique case (exc_pc_mux_i)
      // synchronous exceptions share the base entry
      EXC_PC_EXC: exc_pc = mtvec_base;
      // vectored interrupts, one word per id
      EXC_PC_IRQ: exc_pc = mtvec_base + addr_t'({irq_id_i, 2'b00});
      default:    exc_pc = mtvec_base;
    endcase
  end

  //////////////////////////////
  // redirect mux
  //////////////////////////////

  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: redirect_addr_o = boot_pc;
      PC_JUMP: redirect_addr_o = jump_pc;
      PC_EXC:  redirect_addr_o = exc_pc;
      // return from trap
      PC_ERET: redirect_addr_o = csr_i.mepc;
      default: redirect_addr_o = boot_pc;
    endcase
  end

  // csr file loads its mtvec reset value on the boot jump
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

/* fetch_pkg.sv */
//////////////////////////////
// fetch stage definitions
// widths, enums and structs shared by
// the instruction fetch blocks
//////////////////////////////

package fetch_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  // byte address of an instruction word
  typedef logic [31:0] addr_t;

  // raw 32-bit instruction as read from the bus
  typedef logic [31:0] instr_t;

  // interrupt id used for the vectored entry
  typedef logic [4:0] irq_id_t;

  //////////////////////////////
  // selectors
  //////////////////////////////

  // source of the next fetch address
  typedef enum logic [1:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET
  } pc_sel_e;

  // kind of trap entry
  typedef enum logic {
    EXC_PC_EXC,
    EXC_PC_IRQ
  } exc_pc_sel_e;

  //////////////////////////////
  // bundles
  //////////////////////////////

  // csr values feeding the pc mux
  typedef struct packed {
    addr_t mepc;
    addr_t mtvec;
  } csr_pc_t;

  // one bus response
  typedef struct packed {
    instr_t instr;
    logic   err;
  } fetch_entry_t;

  // payload handed to decode
  typedef struct packed {
    instr_t instr;
    addr_t  pc;
    logic   fetch_err;
  } if_id_t;

  // prefetch queue depth, also caps outstanding requests
  localparam int unsigned FifoDepth = 2;

  // reset entry offset within the boot page
  localparam logic [7:0] BootOffset = 8'h80;

  // low bits of mtvec and boot_addr that are ignored
  localparam int unsigned VecBaseLsb = 8;

endpackage
